// ==== include/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

//////////////////////////////
// Feature map geometry
//////////////////////////////

// Pixels per row
`define CONV_IMAGE_WIDTH 4

// Rows per plane
`define CONV_IMAGE_HEIGHT 4

//////////////////////////////
// Channels and data
//////////////////////////////

// Input planes per frame
`define CONV_CH_IN 3

// Output planes, one replay pass each
`define CONV_CH_OUT 4

// Pixel and weight word
`define CONV_DATA_WIDTH 16

`endif

// ==== hdl/conv_data_pkg.sv ====
`include "conv_cfg.svh"

package conv_data_pkg;

	// Input pixel, also the saturated result
	typedef logic signed [`CONV_DATA_WIDTH-1:0] pxl_t;

	// Kernel weight
	typedef logic signed [`CONV_DATA_WIDTH-1:0] wgt_t;

	// Partial sum over input channels
	// Two guard bits above the full product width
	typedef logic signed [2*`CONV_DATA_WIDTH+1:0] acc_t;

endpackage

// ==== hdl/conv_index_pkg.sv ====
`include "conv_cfg.svh"

package conv_index_pkg;

	// Pixels in one plane and in a whole frame
	localparam int IMAGE_SIZE = `CONV_IMAGE_WIDTH * `CONV_IMAGE_HEIGHT;
	localparam int FRAME_SIZE = IMAGE_SIZE * `CONV_CH_IN;

	// Frame buffer address
	typedef logic [$clog2(FRAME_SIZE)-1:0] faddr_t;

	// Pixel position inside a plane
	typedef logic [$clog2(IMAGE_SIZE)-1:0] pix_t;

	// Input channel
	typedef logic [$clog2(`CONV_CH_IN)-1:0] cin_t;

	// Output channel, same as the replay pass number
	typedef logic [$clog2(`CONV_CH_OUT)-1:0] cout_t;

	// Weight address, output channel times CH_IN plus input channel
	typedef logic [$clog2(`CONV_CH_OUT * `CONV_CH_IN)-1:0] waddr_t;

endpackage

// ==== hdl/conv_sram.sv ====
`timescale 1ns/100ps

module conv_sram #(
	parameter int DEPTH = 16,
	parameter int WIDTH = 16
) (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         wdata,
	output logic [WIDTH-1:0]         rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Read-first port returns the old word on a write
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr];
		end
	end

endmodule

// ==== hdl/conv_replay_buffer.sv ====
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_replay_buffer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   pxl_valid,
	input  conv_data_pkg::pxl_t    pxl_in,
	output logic                   busy,
	output logic                   rep_valid,
	output conv_index_pkg::faddr_t rep_addr,
	output conv_index_pkg::cout_t  rep_pass,
	output conv_data_pkg::pxl_t    rep_pxl,
	output logic                   rep_last
);

	import conv_data_pkg::*;
	import conv_index_pkg::*;

	localparam faddr_t ADDR_LAST = faddr_t'(FRAME_SIZE - 1);
	localparam cout_t  PASS_LAST = cout_t'(`CONV_CH_OUT - 1);

	// Cycles from rep_valid to res_valid further down
	localparam int RESULT_LATENCY = 4;

	pxl_t   pxl_q;
	logic   wr_q;
	faddr_t ld_addr;
	logic   hold;
	logic   accept;

	logic   replay;
	faddr_t rd_addr;
	cout_t  rd_pass;
	logic   [RESULT_LATENCY-1:0] drain;

	logic   ram_en;
	faddr_t ram_addr;

	//////////////////////////////
	// Load phase
	//////////////////////////////

	// Replay, pipeline drain, or the last pixel still on its way into the RAM
	assign hold   = replay | rep_valid | (|drain) | (wr_q & (ld_addr == ADDR_LAST));
	assign accept = pxl_valid & ~hold;

	always_ff @(posedge clk) begin
		if (accept) begin
			pxl_q <= pxl_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_q    <= 1'b0;
			ld_addr <= '0;
		end else begin
			wr_q <= accept;
			if (wr_q) begin
				ld_addr <= (ld_addr == ADDR_LAST) ? '0 : ld_addr + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Replay phase
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			replay  <= 1'b0;
			rd_addr <= '0;
			rd_pass <= '0;
		end else if (wr_q && ld_addr == ADDR_LAST) begin
			// Frame complete
			replay <= 1'b1;
		end else if (replay) begin
			if (rd_addr == ADDR_LAST) begin
				rd_addr <= '0;
				if (rd_pass == PASS_LAST) begin
					rd_pass <= '0;
					replay  <= 1'b0;
				end else begin
					rd_pass <= rd_pass + 1'b1;
				end
			end else begin
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	// Writes and replay reads never overlap
	assign ram_en   = wr_q | replay;
	assign ram_addr = wr_q ? ld_addr : rd_addr;

	conv_sram #(
		.DEPTH(FRAME_SIZE),
		.WIDTH(`CONV_DATA_WIDTH)
	) u_frame_ram (
		.clk  (clk),
		.en   (ram_en),
		.we   (wr_q),
		.addr (ram_addr),
		.wdata(pxl_q),
		.rdata(rep_pxl)
	);

	// Line up tags with RAM read data
	always_ff @(posedge clk) begin
		rep_addr <= rd_addr;
		rep_pass <= rd_pass;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rep_valid <= 1'b0;
			rep_last  <= 1'b0;
			drain     <= '0;
			busy      <= 1'b0;
		end else begin
			rep_valid <= replay;
			rep_last  <= replay & (rd_addr == ADDR_LAST) & (rd_pass == PASS_LAST);
			drain     <= {drain[RESULT_LATENCY-2:0], rep_last};
			// Drops the cycle after done
			if (drain[RESULT_LATENCY-1]) begin
				busy <= 1'b0;
			end else if (accept) begin
				busy <= 1'b1;
			end
		end
	end

endmodule

// ==== hdl/conv_index_decoder.sv ====
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_index_decoder (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rep_valid,
	input  conv_index_pkg::faddr_t rep_addr,
	input  conv_index_pkg::cout_t  rep_pass,
	input  conv_data_pkg::pxl_t    rep_pxl,
	input  logic                   rep_last,
	output logic                   dec_valid,
	output conv_data_pkg::pxl_t    dec_pxl,
	output conv_index_pkg::waddr_t dec_waddr,
	output conv_index_pkg::pix_t   dec_pix,
	output logic                   dec_first,
	output logic                   dec_last_ic,
	output logic                   dec_frame_last
);

	import conv_index_pkg::*;

	localparam cin_t CIN_LAST = cin_t'(`CONV_CH_IN - 1);

	cin_t   cin;
	pix_t   pix;
	waddr_t waddr;

	//////////////////////////////
	// Address split
	//////////////////////////////

	// Channel-major frame layout
	assign cin = cin_t'(rep_addr / IMAGE_SIZE);
	assign pix = pix_t'(rep_addr % IMAGE_SIZE);

	// Weight row per output channel
	assign waddr = waddr_t'(rep_pass * `CONV_CH_IN + cin);

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid      <= 1'b0;
			dec_frame_last <= 1'b0;
		end else begin
			dec_valid      <= rep_valid;
			dec_frame_last <= rep_valid & rep_last;
		end
	end

	always_ff @(posedge clk) begin
		dec_pxl     <= rep_pxl;
		dec_waddr   <= waddr;
		dec_pix     <= pix;
		dec_first   <= (cin == '0);
		dec_last_ic <= (cin == CIN_LAST);
	end

endmodule

// ==== hdl/conv_mac_stage.sv ====
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_mac_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   w_we,
	input  conv_index_pkg::waddr_t w_addr,
	input  conv_data_pkg::wgt_t    w_data,
	input  logic                   dec_valid,
	input  conv_data_pkg::pxl_t    dec_pxl,
	input  conv_index_pkg::waddr_t dec_waddr,
	input  conv_index_pkg::pix_t   dec_pix,
	input  logic                   dec_first,
	input  logic                   dec_last_ic,
	input  logic                   dec_frame_last,
	output logic                   mac_valid,
	output conv_data_pkg::acc_t    mac_sum,
	output logic                   mac_frame_last
);

	import conv_data_pkg::*;
	import conv_index_pkg::*;

	localparam int WGT_DEPTH  = `CONV_CH_OUT * `CONV_CH_IN;
	localparam int BANK_DEPTH = IMAGE_SIZE / 2;
	localparam int PIX_MSB    = $bits(pix_t) - 1;

	logic   wgt_en;
	waddr_t wgt_addr;
	wgt_t   wgt_rd;

	logic   s1_valid;
	pxl_t   s1_pxl;
	pix_t   s1_pix;
	logic   s1_first;
	logic   s1_last_ic;
	logic   s1_frame_last;

	acc_t   ps_base;
	logic signed [2*`CONV_DATA_WIDTH-1:0] prod;
	acc_t   sum_next;

	//////////////////////////////
	// Weight RAM
	//////////////////////////////

	// External writes only happen while idle
	assign wgt_en   = w_we | dec_valid;
	assign wgt_addr = w_we ? w_addr : dec_waddr;

	conv_sram #(
		.DEPTH(WGT_DEPTH),
		.WIDTH(`CONV_DATA_WIDTH)
	) u_wgt_ram (
		.clk  (clk),
		.en   (wgt_en),
		.we   (w_we),
		.addr (wgt_addr),
		.wdata(w_data),
		.rdata(wgt_rd)
	);

	//////////////////////////////
	// Partial sum RAM
	//////////////////////////////

	// Even and odd pixels in separate banks
	// Adjacent items differ in pixel parity, so a read and a writeback never share a port
	for (genvar b = 0; b < 2; b++) begin : g_ps_bank
		logic rd_en;
		logic wr_en;
		logic [PIX_MSB-1:0] addr;
		acc_t rdata;

		assign rd_en = dec_valid & ~dec_first & (dec_pix[0] == 1'(b));
		assign wr_en = s1_valid & ~s1_last_ic & (s1_pix[0] == 1'(b));
		assign addr  = wr_en ? s1_pix[PIX_MSB:1] : dec_pix[PIX_MSB:1];

		conv_sram #(
			.DEPTH(BANK_DEPTH),
			.WIDTH($bits(acc_t))
		) u_ps_ram (
			.clk  (clk),
			.en   (rd_en | wr_en),
			.we   (wr_en),
			.addr (addr),
			.wdata(sum_next),
			.rdata(rdata)
		);
	end

	//////////////////////////////
	// Read stage
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_pxl        <= dec_pxl;
		s1_pix        <= dec_pix;
		s1_first      <= dec_first;
		s1_last_ic    <= dec_last_ic;
		s1_frame_last <= dec_frame_last;
	end

	//////////////////////////////
	// Multiply and accumulate
	//////////////////////////////

	// First input channel starts from zero
	assign ps_base  = s1_first ? '0 : (s1_pix[0] ? g_ps_bank[1].rdata : g_ps_bank[0].rdata);
	assign prod     = s1_pxl * wgt_rd;
	assign sum_next = ps_base + prod;

	always_ff @(posedge clk) begin
		if (reset) begin
			mac_valid      <= 1'b0;
			mac_frame_last <= 1'b0;
		end else begin
			mac_valid      <= s1_valid & s1_last_ic;
			mac_frame_last <= s1_valid & s1_last_ic & s1_frame_last;
		end
	end

	always_ff @(posedge clk) begin
		mac_sum <= sum_next;
	end

endmodule

// ==== hdl/conv_result_stage.sv ====
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_result_stage (
	input  logic                clk,
	input  logic                reset,
	input  logic                relu_en,
	input  logic                mac_valid,
	input  conv_data_pkg::acc_t mac_sum,
	input  logic                mac_frame_last,
	output logic                res_valid,
	output conv_data_pkg::pxl_t res_data,
	output logic                done
);

	import conv_data_pkg::*;

	// Signed pixel range
	localparam acc_t SAT_MAX = (acc_t'(1) <<< (`CONV_DATA_WIDTH - 1)) - acc_t'(1);
	localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

	pxl_t sat_val;
	pxl_t out_val;

	always_comb begin
		if (mac_sum > SAT_MAX) begin
			sat_val = pxl_t'(SAT_MAX);
		end else if (mac_sum < SAT_MIN) begin
			sat_val = pxl_t'(SAT_MIN);
		end else begin
			sat_val = pxl_t'(mac_sum);
		end
	end

	// Optional ReLU
	assign out_val = (relu_en && sat_val < 0) ? '0 : sat_val;

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			done      <= 1'b0;
		end else begin
			res_valid <= mac_valid;
			done      <= mac_valid & mac_frame_last;
		end
	end

	always_ff @(posedge clk) begin
		res_data <= out_val;
	end

endmodule

// ==== hdl/conv_pointwise_top.sv ====
`timescale 1ns/100ps

module conv_pointwise_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   w_we,
	input  conv_index_pkg::waddr_t w_addr,
	input  conv_data_pkg::wgt_t    w_data,
	input  logic                   pxl_valid,
	input  conv_data_pkg::pxl_t    pxl_in,
	input  logic                   relu_en,
	output logic                   busy,
	output logic                   res_valid,
	output conv_data_pkg::pxl_t    res_data,
	output logic                   done
);

	import conv_data_pkg::*;
	import conv_index_pkg::*;

	// Replay to decode
	logic   rep_valid;
	faddr_t rep_addr;
	cout_t  rep_pass;
	pxl_t   rep_pxl;
	logic   rep_last;

	// Decode to execute
	logic   dec_valid;
	pxl_t   dec_pxl;
	waddr_t dec_waddr;
	pix_t   dec_pix;
	logic   dec_first;
	logic   dec_last_ic;
	logic   dec_frame_last;

	// Execute to result
	logic   mac_valid;
	acc_t   mac_sum;
	logic   mac_frame_last;

	conv_replay_buffer u_replay (
		.clk      (clk),
		.reset    (reset),
		.pxl_valid(pxl_valid),
		.pxl_in   (pxl_in),
		.busy     (busy),
		.rep_valid(rep_valid),
		.rep_addr (rep_addr),
		.rep_pass (rep_pass),
		.rep_pxl  (rep_pxl),
		.rep_last (rep_last)
	);

	conv_index_decoder u_decoder (
		.clk           (clk),
		.reset         (reset),
		.rep_valid     (rep_valid),
		.rep_addr      (rep_addr),
		.rep_pass      (rep_pass),
		.rep_pxl       (rep_pxl),
		.rep_last      (rep_last),
		.dec_valid     (dec_valid),
		.dec_pxl       (dec_pxl),
		.dec_waddr     (dec_waddr),
		.dec_pix       (dec_pix),
		.dec_first     (dec_first),
		.dec_last_ic   (dec_last_ic),
		.dec_frame_last(dec_frame_last)
	);

	conv_mac_stage u_mac (
		.clk           (clk),
		.reset         (reset),
		.w_we          (w_we),
		.w_addr        (w_addr),
		.w_data        (w_data),
		.dec_valid     (dec_valid),
		.dec_pxl       (dec_pxl),
		.dec_waddr     (dec_waddr),
		.dec_pix       (dec_pix),
		.dec_first     (dec_first),
		.dec_last_ic   (dec_last_ic),
		.dec_frame_last(dec_frame_last),
		.mac_valid     (mac_valid),
		.mac_sum       (mac_sum),
		.mac_frame_last(mac_frame_last)
	);

	conv_result_stage u_result (
		.clk           (clk),
		.reset         (reset),
		.relu_en       (relu_en),
		.mac_valid     (mac_valid),
		.mac_sum       (mac_sum),
		.mac_frame_last(mac_frame_last),
		.res_valid     (res_valid),
		.res_data      (res_data),
		.done          (done)
	);

endmodule

// ==== tests/conv_pointwise_cases.svh ====
`ifndef CONV_POINTWISE_CASES_SVH
`define CONV_POINTWISE_CASES_SVH

// One entry per frame, applied in order
// CASE_WGT       twelve weights, index oc*3 + ic
// CASE_RAND_PXL  random pixels, otherwise the ramp CASE_PBASE + i * CASE_PSTEP
// CASE_GAP       idle cycles between strobes, an upper bound when CASE_RAND_GAP is set
// CASE_RELU      relu_en for the whole frame

localparam int NUM_CASES = 5;

localparam logic [0:NUM_CASES-1][0:NUM_WGT-1][15:0] CASE_WGT = {
	// Small mixed weights, ramp pixels
	{16'sd1, 16'sd2, 16'sd3, -16'sd1, 16'sd0, 16'sd1,
		16'sd2, -16'sd2, 16'sd1, 16'sd0, 16'sd0, 16'sd5},
	// Negative sums for ReLU
	{-16'sd3, 16'sd1, -16'sd2, 16'sd4, -16'sd1, 16'sd2,
		-16'sd5, -16'sd5, 16'sd1, 16'sd1, 16'sd1, 16'sd1},
	// Extremes, saturate both ways
	{16'sd32767, 16'sd32767, 16'sd32767, 16'h8000, 16'h8000, 16'h8000,
		16'sd1, 16'sd0, 16'sd0, 16'sd0, 16'sd1, -16'sd1},
	// Same frame as the first, random strobe gaps
	{16'sd1, 16'sd2, 16'sd3, -16'sd1, 16'sd0, 16'sd1,
		16'sd2, -16'sd2, 16'sd1, 16'sd0, 16'sd0, 16'sd5},
	// Random pixels
	{16'sd7, -16'sd6, 16'sd5, -16'sd4, 16'sd3, -16'sd2,
		16'sd1, -16'sd1, 16'sd1, 16'sd100, -16'sd100, 16'sd50}
};

localparam logic [0:NUM_CASES-1][15:0] CASE_PBASE = {
	16'sd0, -16'sd24, 16'sd30000, 16'sd0, 16'sd0
};

localparam logic [0:NUM_CASES-1][15:0] CASE_PSTEP = {
	16'sd1, 16'sd1, -16'sd1250, 16'sd1, 16'sd0
};

localparam logic [0:NUM_CASES-1][3:0] CASE_GAP = {4'd0, 4'd2, 4'd0, 4'd3, 4'd1};

localparam logic [0:NUM_CASES-1] CASE_RAND_PXL = 5'b00001;
localparam logic [0:NUM_CASES-1] CASE_RAND_GAP = 5'b00010;
localparam logic [0:NUM_CASES-1] CASE_RELU     = 5'b01001;

`endif

// ==== tests/conv_pointwise_tb.sv ====
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_pointwise_tb;

	import conv_data_pkg::*;
	import conv_index_pkg::*;

	localparam int NUM_PIX = IMAGE_SIZE * `CONV_CH_IN;
	localparam int NUM_WGT = `CONV_CH_OUT * `CONV_CH_IN;
	localparam int NUM_RES = IMAGE_SIZE * `CONV_CH_OUT;
	localparam longint PXL_MAX = (longint'(1) << (`CONV_DATA_WIDTH - 1)) - 1;
	localparam longint PXL_MIN = -PXL_MAX - 1;

	`include "conv_pointwise_cases.svh"

	logic   clk = 1'b0;
	logic   reset;
	logic   w_we;
	waddr_t w_addr;
	wgt_t   w_data;
	logic   pxl_valid;
	pxl_t   pxl_in;
	logic   relu_en;
	logic   busy;
	logic   res_valid;
	pxl_t   res_data;
	logic   done;

	int     seed = 32'ha2f3;
	int     errors = 0;
	int     frame_results = 0;
	int     total_results = 0;
	int     done_count = 0;
	pxl_t   exp_q [$];
	wgt_t   wgt [NUM_WGT];
	pxl_t   pix [NUM_PIX];

	always #2 clk = ~clk;

	conv_pointwise_top u_conv_pointwise_top (
		.clk      (clk),
		.reset    (reset),
		.w_we     (w_we),
		.w_addr   (w_addr),
		.w_data   (w_data),
		.pxl_valid(pxl_valid),
		.pxl_in   (pxl_in),
		.relu_en  (relu_en),
		.busy     (busy),
		.res_valid(res_valid),
		.res_data (res_data),
		.done     (done)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// out[oc][p] is the sum over ic of w[oc][ic] * x[ic][p]
	function automatic pxl_t expected_result(int oc, int p, logic relu);
		longint acc;
		acc = 0;
		for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
			acc += longint'(wgt[oc * `CONV_CH_IN + ic]) * longint'(pix[ic * IMAGE_SIZE + p]);
		end
		if (acc > PXL_MAX) begin
			acc = PXL_MAX;
		end else if (acc < PXL_MIN) begin
			acc = PXL_MIN;
		end
		if (relu && acc < 0) begin
			acc = 0;
		end
		return pxl_t'(acc);
	endfunction

	task automatic build_case(input int c);
		for (int i = 0; i < NUM_WGT; i++) begin
			wgt[i] = CASE_WGT[c][i];
		end
		for (int i = 0; i < NUM_PIX; i++) begin
			if (CASE_RAND_PXL[c]) begin
				pix[i] = pxl_t'($random(seed));
			end else begin
				pix[i] = pxl_t'($signed(CASE_PBASE[c]) + $signed(CASE_PSTEP[c]) * i);
			end
		end
	endtask

	// Output channel major, pixel minor
	task automatic queue_expected(input logic relu);
		for (int oc = 0; oc < `CONV_CH_OUT; oc++) begin
			for (int p = 0; p < IMAGE_SIZE; p++) begin
				exp_q.push_back(expected_result(oc, p, relu));
			end
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic write_weights();
		for (int i = 0; i < NUM_WGT; i++) begin
			@(posedge clk);
			w_we   <= 1'b1;
			w_addr <= waddr_t'(i);
			w_data <= wgt[i];
		end
		@(posedge clk);
		w_we <= 1'b0;
	endtask

	task automatic send_frame(input int c);
		int gap;
		for (int i = 0; i < NUM_PIX; i++) begin
			@(posedge clk);
			pxl_valid <= 1'b1;
			pxl_in    <= pix[i];
			gap = CASE_RAND_GAP[c] ? ($unsigned($random(seed)) % (CASE_GAP[c] + 1)) : CASE_GAP[c];
			repeat (gap) begin
				@(posedge clk);
				pxl_valid <= 1'b0;
			end
		end
		// Junk strobes while the frame replays
		repeat (16) begin
			@(posedge clk);
			pxl_valid <= 1'b1;
			pxl_in    <= pxl_t'($random(seed));
		end
		@(posedge clk);
		pxl_valid <= 1'b0;
	endtask

	task automatic wait_frame_end();
		@(negedge clk);
		while (done !== 1'b1) begin
			assert (busy === 1'b1) else begin
				errors++;
				$display("busy was low at %0t while a frame was still in flight", $time);
			end
			@(negedge clk);
		end
		@(negedge clk);
		assert (busy === 1'b0) else begin
			errors++;
			$display("busy was still high at %0t, one cycle after done", $time);
		end
	endtask

	//////////////////////////////
	// Result monitor
	//////////////////////////////

	always @(negedge clk) begin : monitor
		pxl_t exp_val;
		if (!reset && res_valid === 1'b1) begin
			total_results++;
			frame_results++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("a result came at %0t when none was expected", $time);
			end else begin
				exp_val = exp_q.pop_front();
				assert (res_data === exp_val) else begin
					errors++;
					$display("error: %0t res_data expected %0d actual %0d",
						$time, exp_val, res_data);
				end
			end
		end
		if (!reset && done === 1'b1) begin
			done_count++;
			assert (res_valid === 1'b1 && frame_results == NUM_RES) else begin
				errors++;
				$display("done at %0t came after %0d results of the frame, not with result %0d",
					$time, frame_results, NUM_RES);
			end
			frame_results = 0;
		end
	end

	initial begin : watchdog
		int max_gap;
		int limit;
		max_gap = 0;
		for (int c = 0; c < NUM_CASES; c++) begin
			if (CASE_GAP[c] > max_gap) begin
				max_gap = CASE_GAP[c];
			end
		end
		limit = NUM_CASES * (NUM_PIX * (max_gap + 1) + 300) + 100;
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not end within %0d cycles", limit);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		reset     = 1'b1;
		w_we      = 1'b0;
		w_addr    = '0;
		w_data    = '0;
		pxl_valid = 1'b0;
		pxl_in    = '0;
		relu_en   = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (busy === 1'b0 && res_valid === 1'b0 && done === 1'b0) else begin
			errors++;
			$display("busy, res_valid or done was not low after reset");
		end

		for (int c = 0; c < NUM_CASES; c++) begin
			build_case(c);
			queue_expected(CASE_RELU[c]);
			@(posedge clk);
			relu_en <= CASE_RELU[c];
			write_weights();
			send_frame(c);
			wait_frame_end();
		end

		repeat (4) @(negedge clk);
		assert (exp_q.size() == 0 && done_count == NUM_CASES
			&& total_results == NUM_CASES * NUM_RES) else begin
			errors++;
			$display("got %0d results and %0d done pulses, %0d results still expected",
				total_results, done_count, exp_q.size());
		end

		$display("results %0d, done pulses %0d, errors %0d",
			total_results, done_count, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== conv_pointwise_top.f ====
+incdir+include
+incdir+tests
hdl/conv_data_pkg.sv
hdl/conv_index_pkg.sv
hdl/conv_sram.sv
hdl/conv_replay_buffer.sv
hdl/conv_index_decoder.sv
hdl/conv_mac_stage.sv
hdl/conv_result_stage.sv
hdl/conv_pointwise_top.sv
tests/conv_pointwise_tb.sv

// ==== Bender.yml ====
package:
  name: conv_pointwise

sources:
  - include_dirs:
      - include
    files:
      - hdl/conv_data_pkg.sv
      - hdl/conv_index_pkg.sv
      - hdl/conv_sram.sv
      - hdl/conv_replay_buffer.sv
      - hdl/conv_index_decoder.sv
      - hdl/conv_mac_stage.sv
      - hdl/conv_result_stage.sv
      - hdl/conv_pointwise_top.sv
  - target: test
    include_dirs:
      - include
      - tests
    files:
      - tests/conv_pointwise_tb.sv
